// ==== video_pkg.sv ====
`default_nettype none

package video_pkg;

   typedef logic [7:0] pixel_t;    // Also the Wishbone data word.
   typedef logic [4:0] pf_addr_t;  // Row times h_total plus column.
   typedef logic [2:0] col_t;      // Position in a line, also a line buffer address.
   typedef logic [7:0] line_t;

   // Phase of a line within a pair of displayed rows.
   typedef enum logic [2:0] {
      idle,
      ph0,
      ph1,
      ph2,
      ph3,
      ph4,
      ph5
   } sched_state_t;

endpackage

`default_nettype wire

// ==== line_sched.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_sched #(
   parameter int h_total     = 4,
   parameter int v_total     = 24,
   parameter int v_pf_start  = 5,
   parameter int v_pf_end    = 17,
   parameter int line_repeat = 3
) (
   input  wire logic        clk,
   input  wire logic        reset,
   output video_pkg::col_t  x_cnt,
   output logic             pf,
   output logic             frame_start,
   output logic             render_go,
   output logic             render_sel,
   output logic             disp_sel
);
   import video_pkg::*;

   localparam col_t  x_last   = col_t'(h_total);
   localparam line_t y_last   = line_t'(v_total);
   localparam line_t pf_open  = line_t'(v_pf_start);
   localparam line_t pf_close = line_t'(v_pf_end);
   // Rendering runs two lines ahead of the display.
   localparam line_t rd_open  = line_t'(v_pf_start - 3);
   localparam line_t rd_close = line_t'(v_pf_end - 3);

   // Phase ph_i has the enum value i + 1.
   localparam sched_state_t last_ph = sched_state_t'(2 * line_repeat);
   localparam sched_state_t mid_ph  = sched_state_t'(line_repeat + 1);

   line_t        y_cnt;
   sched_state_t render_ph;
   sched_state_t disp_ph;

   function automatic sched_state_t next_ph(input sched_state_t s);
      if (s == last_ph) begin
         return ph0;
      end
      return sched_state_t'(s + 3'd1);
   endfunction

   always_ff @(posedge clk) begin
      if (reset) begin
         x_cnt       <= col_t'(1);
         y_cnt       <= line_t'(1);
         frame_start <= 1'b0;
      end else begin
         frame_start <= (x_cnt == x_last) && (y_cnt == y_last);  // Next clock is line 1.
         if (x_cnt == x_last) begin
            x_cnt <= col_t'(1);
            y_cnt <= (y_cnt == y_last) ? line_t'(1) : y_cnt + line_t'(1);
         end else begin
            x_cnt <= x_cnt + col_t'(1);
         end
      end
   end

   // Display side, steps at each line end.
   always_ff @(posedge clk) begin
      if (reset) begin
         pf      <= 1'b0;
         disp_ph <= idle;
      end else if (x_cnt == x_last) begin
         if (y_cnt == pf_open) begin
            pf      <= 1'b1;
            disp_ph <= ph0;
         end else if (y_cnt == pf_close) begin
            pf      <= 1'b0;
            disp_ph <= idle;
         end else if (disp_ph != idle) begin
            disp_ph <= next_ph(disp_ph);
         end
      end
   end

   // Render side, same cadence but shifted up by two lines.
   always_ff @(posedge clk) begin
      if (reset) begin
         render_ph <= idle;
      end else if (x_cnt == x_last) begin
         if (y_cnt == rd_open) render_ph <= ph0;
         else if (y_cnt == rd_close) render_ph <= idle;
         else if (render_ph != idle) render_ph <= next_ph(render_ph);
      end
   end

   // A new row starts on phases 0 and line_repeat.
   assign render_go  = (x_cnt == x_last) && (render_ph == ph0 || render_ph == mid_ph);
   assign render_sel = (render_ph >= mid_ph);
   assign disp_sel   = (disp_ph >= mid_ph);

endmodule

`default_nettype wire

// ==== playfield_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module playfield_ram (
   input  wire logic                clk,
   input  wire logic                reset,
   input  wire logic                wb_cyc,
   input  wire logic                wb_stb,
   input  wire logic                wb_we,
   input  wire video_pkg::pf_addr_t wb_adr,
   input  wire video_pkg::pixel_t   wb_dat_w,
   input  wire video_pkg::pf_addr_t fetch_adr,
   output video_pkg::pixel_t        wb_dat_r,
   output logic                     wb_ack,
   output video_pkg::pixel_t        fetch_dat
);
   import video_pkg::*;

   localparam int words = 2 ** $bits(pf_addr_t);

   pixel_t mem [words];
   logic   wb_req;

   // The ack clock is never taken as a new access.
   assign wb_req = wb_cyc && wb_stb && !wb_ack;

   always_ff @(posedge clk) begin
      if (reset) begin
         wb_ack <= 1'b0;
      end else begin
         wb_ack <= wb_req;
      end
   end

   // Host port. One word per acked access.
   always_ff @(posedge clk) begin
      if (wb_req && wb_we) begin
         mem[wb_adr] <= wb_dat_w;
      end
      if (wb_req) begin
         wb_dat_r <= mem[wb_adr];  // Valid while ack is high.
      end
   end

   // Fetch port.
   always_ff @(posedge clk) begin
      fetch_dat <= mem[fetch_adr];
   end

endmodule

`default_nettype wire

// ==== line_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_fetch #(
   parameter int h_total     = 4,
   parameter int v_pf_start  = 5,
   parameter int v_pf_end    = 17,
   parameter int line_repeat = 3
) (
   input  wire logic              clk,
   input  wire logic              reset,
   input  wire logic              frame_start,
   input  wire logic              render_go,
   input  wire logic              render_sel,
   input  wire video_pkg::pixel_t fetch_dat,
   output video_pkg::pf_addr_t    fetch_adr,
   output logic                   lb_we,
   output video_pkg::col_t        lb_wadr,
   output video_pkg::pixel_t      lb_wdat,
   output logic                   lb_bank
);
   import video_pkg::*;

   localparam int    rows     = (v_pf_end - v_pf_start) / line_repeat;
   localparam line_t row_last = line_t'(rows - 1);
   localparam col_t  col_last = col_t'(h_total - 1);

   line_t    row;       // Next row to render.
   pf_addr_t row_base;
   col_t     col;       // Column of the address on fetch_adr.
   logic     active;

   assign row_base = pf_addr_t'(row * h_total);

   always_ff @(posedge clk) begin
      if (reset) begin
         active  <= 1'b0;
         col     <= '0;
         row     <= '0;
         lb_bank <= 1'b0;
         lb_we   <= 1'b0;
      end else begin
         lb_we <= active;  // One clock behind the address.
         if (frame_start) begin
            row <= '0;
         end
         if (render_go) begin
            active  <= 1'b1;
            col     <= '0;
            lb_bank <= render_sel;
            row     <= (row == row_last) ? '0 : row + line_t'(1);
         end else if (active) begin
            col <= col + col_t'(1);
            if (col == col_last) active <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (render_go) begin
         fetch_adr <= row_base;
      end else if (active) begin
         fetch_adr <= fetch_adr + pf_addr_t'(1);
      end
      lb_wadr <= col;
   end

   assign lb_wdat = fetch_dat;  // RAM read register lines up with lb_wadr.

endmodule

`default_nettype wire

// ==== line_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_buffer #(
   parameter int h_total = 4
) (
   input  wire logic              clk,
   input  wire logic              we,
   input  wire video_pkg::col_t   wadr,
   input  wire video_pkg::col_t   radr,
   input  wire video_pkg::pixel_t wdat,
   output video_pkg::pixel_t      rdat
);
   import video_pkg::*;

   localparam int aw = $clog2(h_total);

   pixel_t mem [h_total];  // One pixel per position.

   always_ff @(posedge clk) begin
      if (we) begin
         mem[wadr[aw-1:0]] <= wdat;
      end
      rdat <= mem[radr[aw-1:0]];  // Old data on a same-address collision.
   end

endmodule

`default_nettype wire

// ==== pixel_out.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_out (
   input  wire logic              clk,
   input  wire logic              reset,
   input  wire video_pkg::col_t   x_cnt,
   input  wire logic              pf,
   input  wire logic              disp_sel,
   input  wire video_pkg::pixel_t rdat0,
   input  wire video_pkg::pixel_t rdat1,
   output video_pkg::col_t        lb_radr,
   output video_pkg::pixel_t      pixel,
   output logic                   pixel_valid
);
   import video_pkg::*;

   logic pf_q;   // Lines up with the buffer read data.
   logic sel_q;

   assign lb_radr = x_cnt - col_t'(1);  // Positions count from 1.

   always_ff @(posedge clk) begin
      if (reset) begin
         pf_q        <= 1'b0;
         pixel_valid <= 1'b0;
      end else begin
         pf_q        <= pf;
         pixel_valid <= pf_q;
      end
   end

   always_ff @(posedge clk) begin
      sel_q <= disp_sel;
      if (!pf_q) begin
         pixel <= '0;  // Blank outside the playfield.
      end else begin
         pixel <= sel_q ? rdat1 : rdat0;
      end
   end

endmodule

`default_nettype wire

// ==== video_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_top #(
   parameter int h_total     = 4,
   parameter int v_total     = 24,
   parameter int v_pf_start  = 5,
   parameter int v_pf_end    = 17,
   parameter int line_repeat = 3
) (
   input  wire logic                clk,
   input  wire logic                reset,
   input  wire logic                wb_cyc,
   input  wire logic                wb_stb,
   input  wire logic                wb_we,
   input  wire video_pkg::pf_addr_t wb_adr,
   input  wire video_pkg::pixel_t   wb_dat_w,
   output video_pkg::pixel_t        wb_dat_r,
   output logic                     wb_ack,
   output video_pkg::pixel_t        pixel,
   output logic                     pixel_valid,
   output logic                     frame_start
);
   import video_pkg::*;

   col_t     x_cnt;
   logic     pf;
   logic     render_go;
   logic     render_sel;
   logic     disp_sel;
   pf_addr_t fetch_adr;
   pixel_t   fetch_dat;
   logic     lb_we;
   col_t     lb_wadr;
   pixel_t   lb_wdat;
   logic     lb_bank;
   col_t     lb_radr;
   pixel_t   rdat [2];

   line_sched #(
      .h_total     (h_total),
      .v_total     (v_total),
      .v_pf_start  (v_pf_start),
      .v_pf_end    (v_pf_end),
      .line_repeat (line_repeat)
   ) line_sched_inst (
      .clk         (clk),
      .reset       (reset),
      .x_cnt       (x_cnt),
      .pf          (pf),
      .frame_start (frame_start),
      .render_go   (render_go),
      .render_sel  (render_sel),
      .disp_sel    (disp_sel)
   );

   playfield_ram playfield_ram_inst (
      .clk       (clk),
      .reset     (reset),
      .wb_cyc    (wb_cyc),
      .wb_stb    (wb_stb),
      .wb_we     (wb_we),
      .wb_adr    (wb_adr),
      .wb_dat_w  (wb_dat_w),
      .fetch_adr (fetch_adr),
      .wb_dat_r  (wb_dat_r),
      .wb_ack    (wb_ack),
      .fetch_dat (fetch_dat)
   );

   line_fetch #(
      .h_total     (h_total),
      .v_pf_start  (v_pf_start),
      .v_pf_end    (v_pf_end),
      .line_repeat (line_repeat)
   ) line_fetch_inst (
      .clk         (clk),
      .reset       (reset),
      .frame_start (frame_start),
      .render_go   (render_go),
      .render_sel  (render_sel),
      .fetch_dat   (fetch_dat),
      .fetch_adr   (fetch_adr),
      .lb_we       (lb_we),
      .lb_wadr     (lb_wadr),
      .lb_wdat     (lb_wdat),
      .lb_bank     (lb_bank)
   );

   // Both buffers see the same addresses, writes go to the captured bank only.
   for (genvar b = 0; b < 2; b++) begin : g_lb
      line_buffer #(
         .h_total (h_total)
      ) line_buffer_inst (
         .clk  (clk),
         .we   (lb_we && (lb_bank == 1'(b))),
         .wadr (lb_wadr),
         .radr (lb_radr),
         .wdat (lb_wdat),
         .rdat (rdat[b])
      );
   end

   pixel_out pixel_out_inst (
      .clk         (clk),
      .reset       (reset),
      .x_cnt       (x_cnt),
      .pf          (pf),
      .disp_sel    (disp_sel),
      .rdat0       (rdat[0]),
      .rdat1       (rdat[1]),
      .lb_radr     (lb_radr),
      .pixel       (pixel),
      .pixel_valid (pixel_valid)
   );

endmodule

`default_nettype wire

// ==== video_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_props (
   input wire logic clk,
   input wire logic reset,
   input wire logic wb_cyc,
   input wire logic wb_stb,
   input wire logic wb_ack,
   input wire logic pixel_valid
);

   int fail_count = 0;  // Read by the testbench at the end of the run.

   // Ack only answers a request seen one clock earlier.
   ack_follows_req: assert property (@(posedge clk) disable iff (reset)
      wb_ack |-> $past(wb_cyc && wb_stb))
      else begin
         fail_count++;
         $error("wb_ack raised without cyc and stb on the clock before");
      end

   ack_single_clock: assert property (@(posedge clk) disable iff (reset)
      wb_ack |=> !wb_ack)
      else begin
         fail_count++;
         $error("wb_ack high on two clocks in a row");
      end

   valid_low_after_reset: assert property (@(posedge clk)
      reset |=> !pixel_valid)
      else begin
         fail_count++;
         $error("pixel_valid high on the clock after reset");
      end

endmodule

bind video_top video_props video_props_inst (
   .clk         (clk),
   .reset       (reset),
   .wb_cyc      (wb_cyc),
   .wb_stb      (wb_stb),
   .wb_ack      (wb_ack),
   .pixel_valid (pixel_valid)
);

`default_nettype wire

// ==== video_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_tb;
   import video_pkg::*;

   localparam int h_total     = 4;
   localparam int v_total     = 24;
   localparam int v_pf_start  = 5;
   localparam int v_pf_end    = 17;
   localparam int line_repeat = 3;

   localparam int pf_lines   = v_pf_end - v_pf_start;
   localparam int frame_len  = h_total * v_total;
   localparam int frame_pix  = h_total * pf_lines;
   localparam int words      = 2 ** $bits(pf_addr_t);
   localparam int wb_clocks  = 3 * (2 * words + 8);  // Three clocks per access.
   localparam int max_cycles = 12 * frame_len + 2 * wb_clocks;

   logic     clk;
   logic     reset;
   logic     wb_cyc;
   logic     wb_stb;
   logic     wb_we;
   pf_addr_t wb_adr;
   pixel_t   wb_dat_w;
   pixel_t   wb_dat_r;
   logic     wb_ack;
   pixel_t   pixel;
   logic     pixel_valid;
   logic     frame_start;

   pixel_t      model [words];  // Mirror of the playfield memory.
   logic [31:0] rng_state;
   int          errors;
   int          tests_run;
   int          tests_failed;
   int          cycles = 0;

   video_top #(
      .h_total     (h_total),
      .v_total     (v_total),
      .v_pf_start  (v_pf_start),
      .v_pf_end    (v_pf_end),
      .line_repeat (line_repeat)
   ) video_top_inst (
      .clk         (clk),
      .reset       (reset),
      .wb_cyc      (wb_cyc),
      .wb_stb      (wb_stb),
      .wb_we       (wb_we),
      .wb_adr      (wb_adr),
      .wb_dat_w    (wb_dat_w),
      .wb_dat_r    (wb_dat_r),
      .wb_ack      (wb_ack),
      .pixel       (pixel),
      .pixel_valid (pixel_valid),
      .frame_start (frame_start)
   );

   initial clk = 1'b0;
   always #50 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= max_cycles) begin
         $display("Timeout after %0d clocks, the DUT stopped making progress", cycles);
         $display("Test failures found");
         $finish;
      end
   end

   function automatic logic [31:0] next_random();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   // One classic cycle, then one idle clock.
   task automatic wb_access(input logic we, input pf_addr_t adr, input pixel_t wdat,
                            output pixel_t rdat);
      int wait_clk;
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= we;
      wb_adr   <= adr;
      wb_dat_w <= wdat;
      wait_clk = 0;
      do begin
         @(posedge clk);
         wait_clk++;
      end while (wb_ack !== 1'b1 && wait_clk < 8);
      if (wb_ack !== 1'b1) begin
         $display("Wishbone access to address %0d was never acknowledged", adr);
         errors++;
      end
      rdat = wb_dat_r;
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
      @(posedge clk);
   endtask

   task automatic fill_memory();
      logic [31:0] r;
      pixel_t      rd;
      for (int i = 0; i < words; i++) begin
         r = next_random();
         model[pf_addr_t'(i)] = r[15:8];
         wb_access(1'b1, pf_addr_t'(i), r[15:8], rd);
      end
   endtask

   task automatic check_readback();
      logic [31:0] r;
      pf_addr_t    adr;
      pixel_t      rd;
      for (int i = 0; i < 8; i++) begin
         r = next_random();
         adr = r[12:8];
         wb_access(1'b0, adr, 8'h00, rd);
         if (rd !== model[adr]) begin
            $display("FAIL %0t wb_dat_r got %02h expected %02h", $time, rd, model[adr]);
            errors++;
         end
      end
   endtask

   task automatic wait_frame_start();
      do begin
         @(posedge clk);
      end while (frame_start !== 1'b1);
   endtask

   // Runs from one frame_start to the next and compares every valid pixel.
   task automatic check_frame(output int pix_bad, output int len_bad);
      int     n;
      int     idx;
      int     row;
      int     col;
      pixel_t want;
      n = 0;
      idx = 0;
      pix_bad = 0;
      len_bad = 0;
      do begin
         @(posedge clk);
         n++;
         if (pixel_valid === 1'b1) begin
            if (idx < frame_pix) begin
               row = (idx / h_total) / line_repeat;  // Each row spans line_repeat lines.
               col = idx % h_total;
               want = model[pf_addr_t'(row * h_total + col)];
               if (pixel !== want) begin
                  $display("FAIL %0t pixel got %02h expected %02h", $time, pixel, want);
                  pix_bad++;
               end
            end
            idx++;
         end
      end while (frame_start !== 1'b1);
      if (idx != frame_pix) begin
         $display("FAIL %0t pixel_valid count got %0d expected %0d", $time, idx, frame_pix);
         len_bad++;
      end
      if (n != frame_len) begin
         $display("FAIL %0t frame_start period got %0d expected %0d", $time, n, frame_len);
         len_bad++;
      end
   endtask

   task automatic finish_test(input int num, input string name, input int bad);
      tests_run++;
      if (bad == 0) begin
         $display("Test %0d %s: passed", num, name);
      end else begin
         tests_failed++;
         $display("Test %0d %s: %0d errors", num, name, bad);
      end
   endtask

   initial begin
      int start;
      int pix_bad;
      int len_bad;
      reset    <= 1'b1;
      wb_cyc   <= 1'b0;
      wb_stb   <= 1'b0;
      wb_we    <= 1'b0;
      wb_adr   <= '0;
      wb_dat_w <= '0;
      rng_state = 32'h4573;
      errors = 0;
      tests_run = 0;
      tests_failed = 0;
      repeat (3) @(posedge clk);
      reset <= 1'b0;
      @(posedge clk);

      start = errors;
      fill_memory();
      check_readback();
      finish_test(1, "Wishbone write and readback", errors - start);

      wait_frame_start();  // The writes may overlap this frame.
      wait_frame_start();
      check_frame(pix_bad, len_bad);
      errors += pix_bad + len_bad;
      finish_test(2, "frame pixels against model", pix_bad);
      finish_test(3, "pixel count and frame length", len_bad);

      start = errors;
      fill_memory();
      wait_frame_start();
      wait_frame_start();
      check_frame(pix_bad, len_bad);
      errors += pix_bad + len_bad;
      finish_test(4, "frame after memory rewrite", errors - start);

      start = errors;
      wait_frame_start();
      repeat (8 * h_total) @(posedge clk);  // Line 9 lies inside the playfield.
      reset  <= 1'b1;
      wb_cyc <= 1'b1;  // A request that would be acked without the reset.
      wb_stb <= 1'b1;
      wb_we  <= 1'b0;
      @(posedge clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      @(posedge clk);
      if (pixel_valid !== 1'b0) begin
         $display("FAIL %0t pixel_valid got %b expected 0", $time, pixel_valid);
         errors++;
      end
      if (wb_ack !== 1'b0) begin
         $display("FAIL %0t wb_ack got %b expected 0", $time, wb_ack);
         errors++;
      end
      @(posedge clk);
      reset <= 1'b0;
      wait_frame_start();
      check_frame(pix_bad, len_bad);
      errors += pix_bad + len_bad;
      finish_test(5, "reset in mid frame", errors - start);

      errors += video_top_inst.video_props_inst.fail_count;
      $display("Tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
               tests_run, tests_run - tests_failed, tests_failed, errors);
      if (errors == 0 && tests_failed == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== sources.f ====
video_pkg.sv
line_sched.sv
playfield_ram.sv
line_fetch.sv
line_buffer.sv
pixel_out.sv
video_top.sv
video_props.sv
video_tb.sv

// ==== Makefile ====
SIM      := verilator
TOP      := video_tb
FILELIST := sources.f
FLAGS    := --binary --timing --assert -j 0
OBJDIR   := obj_dir
PASS_MSG := All tests passed!

SOURCES  := $(shell cat $(FILELIST))
BIN      := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
